// File: tcdm_stimulus.txt
# test req_valid wen(1=read) add data be user rsp_ready bank_stall(2=random) clear exp_data exp_user
# add data be user exp_data exp_user in hex; exp_data and exp_user are 0 on non-read lines
1 1 0 10 11223344 f 0 1 0 0 00000000 0
1 1 0 11 deadbeef f 0 1 0 0 00000000 0
1 1 0 12 a5a5a5a5 f 0 1 0 0 00000000 0
1 1 0 13 01234567 f 0 1 0 0 00000000 0
1 1 0 10 ffffffff 3 0 1 0 0 00000000 0
1 1 0 11 00000000 c 0 1 0 0 00000000 0
1 1 0 13 99887766 5 0 1 0 0 00000000 0
1 1 0 12 5a5a5a5a 8 0 1 0 0 00000000 0
1 1 1 10 00000000 0 1 1 0 0 1122ffff 1
1 1 1 11 00000000 0 2 1 0 0 0000beef 2
1 1 1 12 00000000 0 3 1 0 0 5aa5a5a5 3
1 1 1 13 00000000 0 4 1 0 0 01884566 4
2 1 0 20 cafef00d f 0 1 2 0 00000000 0
2 1 1 10 00000000 0 5 1 2 0 1122ffff 5
2 1 0 21 0badc0de f 0 1 2 0 00000000 0
2 1 1 20 00000000 0 6 1 2 0 cafef00d 6
2 1 0 20 000000ff 1 0 1 2 0 00000000 0
2 1 1 20 00000000 0 7 1 2 0 cafef0ff 7
2 1 1 21 00000000 0 8 1 2 0 0badc0de 8
2 1 0 22 76543210 f 0 1 2 0 00000000 0
2 1 1 22 00000000 0 9 1 2 0 76543210 9
2 1 1 13 00000000 0 a 1 2 0 01884566 a
3 1 1 10 00000000 0 b 0 0 0 1122ffff b
3 1 1 11 00000000 0 c 0 0 0 0000beef c
3 1 1 12 00000000 0 d 0 0 0 5aa5a5a5 d
3 1 1 13 00000000 0 e 0 0 0 01884566 e
3 1 1 20 00000000 0 f 0 0 0 cafef0ff f
3 1 1 21 00000000 0 0 0 0 0 0badc0de 0
3 1 1 22 00000000 0 1 0 0 0 76543210 1
3 1 1 10 00000000 0 2 0 0 0 1122ffff 2
3 1 1 11 00000000 0 3 0 0 0 0000beef 3
3 0 0 00 00000000 0 0 0 0 0 00000000 0
3 0 0 00 00000000 0 0 0 0 0 00000000 0
3 0 0 00 00000000 0 0 0 0 0 00000000 0
4 1 1 10 00000000 0 6 0 0 0 1122ffff 6
4 1 1 11 00000000 0 7 0 0 0 0000beef 7
4 1 1 12 00000000 0 8 0 1 0 5aa5a5a5 8
4 1 1 13 00000000 0 9 0 1 0 01884566 9
4 0 0 00 00000000 0 0 0 1 1 00000000 0
4 0 0 00 00000000 0 0 1 0 0 00000000 0
4 1 1 20 00000000 0 4 1 0 0 cafef0ff 4
4 1 1 22 00000000 0 5 1 0 0 76543210 5
5 1 0 30 13572468 f 0 1 1 0 00000000 0
5 1 1 30 00000000 0 1 1 1 0 13572468 1
5 0 0 00 00000000 0 0 1 1 0 00000000 0
5 0 0 00 00000000 0 0 1 1 0 00000000 0
5 0 0 00 00000000 0 0 1 0 0 00000000 0
5 1 1 21 00000000 0 2 0 0 0 0badc0de 2
5 0 0 00 00000000 0 0 0 0 0 00000000 0
5 0 0 00 00000000 0 0 0 0 0 00000000 0
5 0 0 00 00000000 0 0 1 0 0 00000000 0

// File: project.f
+incdir+.
tcdm_pkg.sv
stream_fifo.sv
tcdm_core_fifo.sv
tcdm_mem_bank.sv
tcdm_fifo_sys.sv
tcdm_fifo_asserts.sv
tb_tcdm_fifo_sys.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the TCDM FIFO testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_tcdm_fifo_sys -f project.f

status=0
out=$(./obj_dir/Vtb_tcdm_fifo_sys 2>&1) || status=$?
echo "$out"

if grep -qx "Everything OK" <<< "$out"; then
  exit "$status"
else
  exit 1
fi

// File: tb_tcdm_fifo_sys.sv
////////////////////////////////////////
// testbench for tcdm_fifo_sys, plays the master
// stimulus from tcdm_stimulus.txt, one line per cycle
// bank_stall column 2 means a random stall
// only read addresses that were written before
////////////////////////////////////////

`default_nettype none

`include "tcdm_consts.svh"

module tb_tcdm_fifo_sys
  import tcdm_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          HALF_PERIOD       = 10;
  localparam int          RESET_CYCLES      = 5;
  localparam int          BYTE_W            = `TCDM_DATA_W / `TCDM_BE_W;
  localparam int          BACKPRESSURE_TEST = 3;
  localparam string       STIM_FILE         = "tcdm_stimulus.txt";
  localparam logic [31:0] SEED              = 32'h0e27f708;

  typedef struct packed {
    int         test;
    logic       req_valid;
    logic       wen;
    addr_t      add;
    data_t      data;
    be_t        be;
    user_t      user;
    logic       rsp_ready;
    logic [1:0] stall;
    logic       clear;
    data_t      exp_data;
    user_t      exp_user;
  } stim_t;

  logic        clk;
  logic        rst_n;
  logic        clear;
  tcdm_req_t   req;
  logic        req_valid;
  logic        gnt;
  tcdm_rsp_t   rsp;
  logic        rsp_valid;
  logic        rsp_ready;
  logic        bank_stall;
  fifo_flags_t flags;

  data_t     mem_model [`TCDM_BANK_WORDS];
  tcdm_rsp_t exp_q [$];     // reads accepted, not yet consumed
  stim_t     stim_q [$];
  int        limit_cycles  = 0;
  int        cycle_cnt     = 0;
  int        checks        = 0;
  int        test_errors   = 0;
  int        total_errors  = 0;
  int        test_rsps     = 0;
  int        tests_run     = 0;
  bit        after_clear   = 1'b0;
  bit        gnt_low_seen  = 1'b0;

  tcdm_fifo_sys dut (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .clear_i      ( clear      ),
    .req_i        ( req        ),
    .req_valid_i  ( req_valid  ),
    .gnt_o        ( gnt        ),
    .rsp_o        ( rsp        ),
    .rsp_valid_o  ( rsp_valid  ),
    .rsp_ready_i  ( rsp_ready  ),
    .bank_stall_i ( bank_stall ),
    .flags_o      ( flags      )
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    while (cycle_cnt < limit_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: timeout, run did not end within %0d cycles", limit_cycles);
    $display("Something failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    n;
    int    f [12];
    string line;
    stim_t s;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open %s", STIM_FILE);
      total_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;    // comment or blank
      n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                  f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
      if (n != 12) begin
        $display("ERROR: stimulus line with %0d fields instead of 12: %s", n, line);
        total_errors++;
        continue;
      end
      s.test      = f[0];
      s.req_valid = f[1][0];
      s.wen       = f[2][0];
      s.add       = addr_t'(f[3]);
      s.data      = data_t'(f[4]);
      s.be        = be_t'(f[5]);
      s.user      = user_t'(f[6]);
      s.rsp_ready = f[7][0];
      s.stall     = f[8][1:0];
      s.clear     = f[9][0];
      s.exp_data  = data_t'(f[10]);
      s.exp_user  = user_t'(f[11]);
      stim_q.push_back(s);
    end
    $fclose(fd);
  endtask

  task automatic drive_inputs(input stim_t s);
    req_valid  = s.req_valid;
    req.add    = s.add;
    req.data   = s.data;
    req.be     = s.be;
    req.wen    = s.wen;
    req.user   = s.user;
    rsp_ready  = s.rsp_ready;
    clear      = s.clear;
    bank_stall = (s.stall == 2'd2) ? (($urandom % 3) == 0) : s.stall[0];
  endtask

  // a read takes its expected data from the model at acceptance
  task automatic accept_request(input stim_t s);
    tcdm_rsp_t exp;
    if (!s.wen) begin
      for (int b = 0; b < `TCDM_BE_W; b++) begin
        if (s.be[b]) mem_model[s.add][BYTE_W*b +: BYTE_W] = s.data[BYTE_W*b +: BYTE_W];
      end
    end else begin
      exp.r_data = mem_model[s.add];
      exp.r_user = s.user;
      checks++;
      assert (exp.r_data === s.exp_data && exp.r_user === s.exp_user) else begin
        $display("ERROR at %0t: stimulus expects %h/%h at %h, memory model holds %h/%h",
                 $time, s.exp_data, s.exp_user, s.add, exp.r_data, exp.r_user);
        test_errors++;
      end
      exp_q.push_back(exp);
    end
  endtask

  task automatic check_response();
    tcdm_rsp_t exp;
    checks++;
    assert (exp_q.size() != 0) else begin
      $display("ERROR at %0t: response %h with tag %h arrived with no read outstanding",
               $time, rsp.r_data, rsp.r_user);
      test_errors++;
    end
    if (exp_q.size() != 0) begin
      exp = exp_q.pop_front();
      check_value("rsp_o.r_data", rsp.r_data, exp.r_data);
      check_value("rsp_o.r_user", 32'(rsp.r_user), 32'(exp.r_user));
      test_rsps++;
    end
  endtask

  // starts and ends on a falling edge, samples 1 ns before the rising edge
  task automatic run_cycle(input stim_t s, output bit accepted);
    drive_inputs(s);
    #(HALF_PERIOD - 1);
    if (after_clear) begin
      check_value("rsp_valid_o", 32'(rsp_valid), 32'd0);
      check_value("flags_o.empty", 32'(flags.empty), 32'd1);
      check_value("flags_o.full", 32'(flags.full), 32'd0);
    end
    if (exp_q.size() != 0) check_value("flags_o.empty", 32'(flags.empty), 32'd0);
    if (!gnt) gnt_low_seen = 1'b1;
    if (s.clear) begin
      exp_q.delete();    // everything pending is dropped
    end else if (rsp_valid && rsp_ready) begin
      check_response();
    end
    after_clear = s.clear;
    accepted = s.req_valid && gnt;
    if (accepted) accept_request(s);
    @(negedge clk);
  endtask

  task automatic drain_dut();
    stim_t idle;
    bit    acc;
    idle = '0;
    idle.rsp_ready = 1'b1;
    while (exp_q.size() != 0 || !flags.empty) run_cycle(idle, acc);
    run_cycle(idle, acc);    // catches a stray response
  endtask

  task automatic finish_test(input int test);
    if (test == BACKPRESSURE_TEST) begin
      // responses still blocked, so the outgoing FIFO has filled up
      check_value("flags_o.full", 32'(flags.full), 32'd1);
    end
    drain_dut();
    if (test == BACKPRESSURE_TEST) begin
      checks++;
      assert (gnt_low_seen) else begin
        $display("ERROR: gnt_o never dropped under response back-pressure");
        test_errors++;
      end
    end
    $display("test %0d finished: %0d responses checked, %0d errors",
             test, test_rsps, test_errors);
    total_errors += test_errors;
    test_errors  = 0;
    test_rsps    = 0;
    gnt_low_seen = 1'b0;
    tests_run++;
  endtask

  initial begin : main
    stim_t cur;
    bit    acc;
    int    idx;
    int    cur_test;
    rst_n      = 1'b0;
    clear      = 1'b0;
    req        = '0;
    req_valid  = 1'b0;
    rsp_ready  = 1'b0;
    bank_stall = 1'b0;
    void'($urandom(SEED));
    load_stimulus();
    limit_cycles = 2 * stim_q.size() + 100;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #(HALF_PERIOD - 1);
    check_value("flags_o.empty", 32'(flags.empty), 32'd1);
    check_value("flags_o.full", 32'(flags.full), 32'd0);
    check_value("gnt_o", 32'(gnt), 32'd1);
    check_value("rsp_valid_o", 32'(rsp_valid), 32'd0);
    @(negedge clk);
    if (stim_q.size() != 0) begin
      idx = 0;
      cur_test = stim_q[0].test;
      while (idx < stim_q.size()) begin
        cur = stim_q[idx];
        if (cur.test != cur_test) begin
          finish_test(cur_test);
          cur_test = cur.test;
        end
        run_cycle(cur, acc);
        if (!cur.req_valid || acc) idx++;    // request line held until granted
      end
      finish_test(cur_test);
    end
    total_errors += test_errors;
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
    if (total_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tcdm_fifo_asserts.sv
////////////////////////////////////////
// protocol checks bound into tcdm_core_fifo
// active only while rst_ni is high
////////////////////////////////////////

`default_nettype none

module tcdm_fifo_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic clear_i,
  input logic in_ready_i,        // incoming FIFO not full
  input logic out_ready_i,       // outgoing FIFO not full
  input logic capt_valid_i,      // capture slot in use
  input logic bank_gnt_i,
  input logic bank_rsp_valid_i,
  input logic rsp_valid_i,
  input logic gnt_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // issue is held back early enough that a late response still finds the slot free
  no_issue_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bank_rsp_valid_i && !in_ready_i |-> !capt_valid_i)
    else $error("response arrived with the incoming FIFO and the capture slot full");

  // also covers a read granted in the cycle of the clear
  rsp_low_after_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (clear_i || $past(clear_i)) |=> !rsp_valid_i)
    else $error("response valid after clear");

  // a full outgoing FIFO only drains through a bank grant
  no_gnt_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !out_ready_i && !bank_gnt_i && !clear_i |=> !gnt_i)
    else $error("grant given while the outgoing FIFO is still full");

endmodule

bind tcdm_core_fifo tcdm_fifo_asserts i_fifo_asserts (
  .clk_i            ( clk_i            ),
  .rst_ni           ( rst_ni           ),
  .clear_i          ( clear_i          ),
  .in_ready_i       ( in_ready         ),
  .out_ready_i      ( out_ready        ),
  .capt_valid_i     ( capt_valid_q     ),
  .bank_gnt_i       ( bank_gnt_i       ),
  .bank_rsp_valid_i ( bank_rsp_valid_i ),
  .rsp_valid_i      ( rsp_valid_o      ),
  .gnt_i            ( gnt_o            )
);

`default_nettype wire

// File: tcdm_fifo_sys.sv
////////////////////////////////////////
// core FIFO in front of one memory bank
// bank_stall_i holds off bank grants
////////////////////////////////////////

`default_nettype none

module tcdm_fifo_sys
  import tcdm_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  tcdm_req_t   req_i,
  input  logic        req_valid_i,
  output logic        gnt_o,
  output tcdm_rsp_t   rsp_o,
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  input  logic        bank_stall_i,
  output fifo_flags_t flags_o
);

  tcdm_req_t bank_req;
  logic      bank_req_valid;
  logic      bank_gnt;
  tcdm_rsp_t bank_rsp;
  logic      bank_rsp_valid;

  tcdm_core_fifo i_core_fifo (
    .clk_i            ( clk_i          ),
    .rst_ni           ( rst_ni         ),
    .clear_i          ( clear_i        ),
    .req_i            ( req_i          ),
    .req_valid_i      ( req_valid_i    ),
    .gnt_o            ( gnt_o          ),
    .rsp_o            ( rsp_o          ),
    .rsp_valid_o      ( rsp_valid_o    ),
    .rsp_ready_i      ( rsp_ready_i    ),
    .bank_req_o       ( bank_req       ),
    .bank_req_valid_o ( bank_req_valid ),
    .bank_gnt_i       ( bank_gnt       ),
    .bank_rsp_i       ( bank_rsp       ),
    .bank_rsp_valid_i ( bank_rsp_valid ),
    .flags_o          ( flags_o        )
  );

  tcdm_mem_bank i_mem_bank (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .req_i       ( bank_req       ),
    .req_valid_i ( bank_req_valid ),
    .stall_i     ( bank_stall_i   ),
    .gnt_o       ( bank_gnt       ),
    .rsp_o       ( bank_rsp       ),
    .rsp_valid_o ( bank_rsp_valid )
  );

endmodule

`default_nettype wire

// File: tcdm_mem_bank.sv
////////////////////////////////////////
// single-port word memory bank
// read data comes one cycle after gnt_o
// writes give no response
// contents are not cleared by reset
////////////////////////////////////////

`default_nettype none

`include "tcdm_consts.svh"

module tcdm_mem_bank
  import tcdm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t req_i,
  input  logic      req_valid_i,
  input  logic      stall_i,     // stands in for contention
  output logic      gnt_o,
  output tcdm_rsp_t rsp_o,
  output logic      rsp_valid_o
);

  localparam int unsigned BYTE_W = `TCDM_DATA_W / `TCDM_BE_W;

  data_t mem_q [`TCDM_BANK_WORDS];
  data_t rdata_q;
  user_t ruser_q;
  logic  rvalid_q;

  assign gnt_o = req_valid_i & ~stall_i;

  always_ff @(posedge clk_i) begin
    if (gnt_o & ~req_i.wen) begin
      for (int b = 0; b < `TCDM_BE_W; b++) begin
        if (req_i.be[b]) begin
          mem_q[req_i.add][BYTE_W*b +: BYTE_W] <= req_i.data[BYTE_W*b +: BYTE_W];
        end
      end
    end
    if (gnt_o & req_i.wen) begin
      rdata_q <= mem_q[req_i.add];
      ruser_q <= req_i.user;    // tag is echoed unchanged
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= gnt_o & req_i.wen;
    end
  end

  assign rsp_o.r_data = rdata_q;
  assign rsp_o.r_user = ruser_q;
  assign rsp_valid_o  = rvalid_q;

endmodule

`default_nettype wire

// File: tcdm_core_fifo.sv
////////////////////////////////////////
// decoupling FIFO pair for one TCDM port
// bank must answer a read exactly 1 cycle after gnt
// clear_i drops pending requests and responses
// no boffs, single master only
////////////////////////////////////////

`default_nettype none

`include "tcdm_consts.svh"

module tcdm_core_fifo
  import tcdm_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  // master side
  input  tcdm_req_t   req_i,
  input  logic        req_valid_i,
  output logic        gnt_o,
  output tcdm_rsp_t   rsp_o,
  output logic        rsp_valid_o,
  input  logic        rsp_ready_i,
  // bank side
  output tcdm_req_t   bank_req_o,
  output logic        bank_req_valid_o,
  input  logic        bank_gnt_i,
  input  tcdm_rsp_t   bank_rsp_i,
  input  logic        bank_rsp_valid_i,
  output fifo_flags_t flags_o
);

  localparam int unsigned REQ_W = $bits(tcdm_req_t);
  localparam int unsigned RSP_W = $bits(tcdm_rsp_t);

  fifo_flags_t      flags_out;
  fifo_flags_t      flags_in;
  logic             out_ready;
  logic             out_valid;
  logic [REQ_W-1:0] out_pop_data;
  logic             in_push;
  logic             in_ready;
  logic             in_valid;
  tcdm_rsp_t        in_push_data;
  logic [RSP_W-1:0] in_pop_data;
  logic             capt_valid_q;
  tcdm_rsp_t        capt_q;
  logic             rd_inflight_q;

  // outgoing requests
  // no grant during clear, the push would be dropped anyway
  assign gnt_o = out_ready & ~clear_i;

  stream_fifo #(
    .DATA_W ( REQ_W            ),
    .DEPTH  ( `TCDM_FIFO_DEPTH )
  ) i_fifo_outgoing (
    .clk_i   ( clk_i               ),
    .rst_ni  ( rst_ni              ),
    .clear_i ( clear_i             ),
    .push_i  ( req_valid_i & gnt_o ),
    .data_i  ( req_i               ),
    .pop_i   ( bank_gnt_i          ),
    .data_o  ( out_pop_data        ),
    .valid_o ( out_valid           ),
    .ready_o ( out_ready           ),
    .flags_o ( flags_out           )
  );

  assign bank_req_o = tcdm_req_t'(out_pop_data);
  // issue only with room for the answer, and never into a clear
  assign bank_req_valid_o = out_valid & in_ready & ~clear_i;

  // incoming responses
  // the captured response is older, so it goes first
  assign in_push      = capt_valid_q | bank_rsp_valid_i;
  assign in_push_data = capt_valid_q ? capt_q : bank_rsp_i;

  // one slot is enough: a response only follows a grant given with room
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      capt_valid_q <= 1'b0;
    end else if (clear_i) begin
      capt_valid_q <= 1'b0;
    end else if (bank_rsp_valid_i & (capt_valid_q | ~in_ready)) begin
      capt_valid_q <= 1'b1;    // new response could not go in directly
    end else if (in_ready) begin
      capt_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bank_rsp_valid_i) capt_q <= bank_rsp_i;
  end

  // a granted read sits in the bank for one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_inflight_q <= 1'b0;
    end else if (clear_i) begin
      rd_inflight_q <= 1'b0;
    end else begin
      rd_inflight_q <= bank_gnt_i & bank_req_o.wen;
    end
  end

  stream_fifo #(
    .DATA_W ( RSP_W            ),
    .DEPTH  ( `TCDM_FIFO_DEPTH )
  ) i_fifo_incoming (
    .clk_i   ( clk_i        ),
    .rst_ni  ( rst_ni       ),
    .clear_i ( clear_i      ),
    .push_i  ( in_push      ),
    .data_i  ( in_push_data ),
    .pop_i   ( rsp_ready_i  ),
    .data_o  ( in_pop_data  ),
    .valid_o ( in_valid     ),
    .ready_o ( in_ready     ),
    .flags_o ( flags_in     )
  );

  assign rsp_o       = tcdm_rsp_t'(in_pop_data);
  assign rsp_valid_o = in_valid;

  // empty also covers a read held in the bank or in the capture slot
  assign flags_o.empty = flags_out.empty & flags_in.empty & ~capt_valid_q & ~rd_inflight_q;
  assign flags_o.full  = flags_out.full;

endmodule

`default_nettype wire

// File: stream_fifo.sv
////////////////////////////////////////
// synchronous FIFO, no fall-through
// push on full and pop on empty are dropped
// clear_i wins over push and pop
////////////////////////////////////////

`default_nettype none

module stream_fifo
  import tcdm_pkg::*;
#(
  parameter int unsigned DATA_W = 32,
  parameter int unsigned DEPTH  = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              push_i,
  input  logic [DATA_W-1:0] data_i,
  input  logic              pop_i,
  output logic [DATA_W-1:0] data_o,
  output logic              valid_o,
  output logic              ready_o,
  output fifo_flags_t       flags_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;    // occupancy
  logic              empty;
  logic              full;
  logic              do_push;
  logic              do_pop;

  // wrap at DEPTH, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign empty   = (cnt_q == '0);
  assign full    = (cnt_q == CNT_W'(DEPTH));
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + CNT_W'(1);
        2'b01:   cnt_q <= cnt_q - CNT_W'(1);
        default: ;    // both or neither, count holds
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  assign data_o        = mem_q[rd_ptr_q];
  assign valid_o       = ~empty;
  assign ready_o       = ~full;
  assign flags_o.empty = empty;
  assign flags_o.full  = full;

endmodule

`default_nettype wire

// File: tcdm_pkg.sv
////////////////////////////////////////
// types for the TCDM request/response path
// wen high means read, as on the TCDM bus
////////////////////////////////////////

`default_nettype none

`include "tcdm_consts.svh"

package tcdm_pkg;

  typedef logic [`TCDM_ADDR_W-1:0] addr_t;
  typedef logic [`TCDM_DATA_W-1:0] data_t;
  typedef logic [`TCDM_BE_W-1:0]   be_t;
  typedef logic [`TCDM_USER_W-1:0] user_t;

  // request as issued by the master, 49 bits
  typedef struct packed {
    addr_t add;
    data_t data;
    be_t   be;
    logic  wen;   // 1 read, 0 write
    user_t user;
  } tcdm_req_t;

  // read response, 36 bits
  typedef struct packed {
    data_t r_data;
    user_t r_user;
  } tcdm_rsp_t;

  typedef struct packed {
    logic empty;
    logic full;
  } fifo_flags_t;

endpackage

`default_nettype wire

// File: tcdm_consts.svh
////////////////////////////////////////
// widths and sizes shared by the TCDM FIFO
// TCDM_DATA_W must be TCDM_BE_W bytes wide
// TCDM_BANK_WORDS must fit in TCDM_ADDR_W
////////////////////////////////////////

`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

`define TCDM_ADDR_W      8    // word address
`define TCDM_DATA_W      32
`define TCDM_BE_W        4    // one enable per byte
`define TCDM_USER_W      4    // tag echoed with the response

`define TCDM_FIFO_DEPTH  4    // same depth for both directions

`define TCDM_BANK_WORDS  256

`endif
